/* rtl/uart_line_pkg.sv */
package uart_line_pkg;

	// Ticks per bit on the serial line. The receiver is built around this ratio.
	localparam int OVERSAMPLE = 16;

	// Data bits per character for the 8N1 format.
	localparam int DATA_BITS = 8;

	// Deserializer states.
	typedef enum logic [1:0] {
		RX_IDLE      = 2'd0,
		RX_START_BIT = 2'd1,
		RX_DATA_BITS = 2'd2,
		RX_STOP_BIT  = 2'd3
	} rx_state_e;

	// One received character as it travels from the deserializer to the host.
	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic                 frame_err;  // Stop bit was sampled low.
	} rx_frame_t;

endpackage

/* rtl/uart_host_pkg.sv */
package uart_host_pkg;

	// Width of the word the host reads.
	localparam int RDATA_WIDTH = 32;

	// Read sequencer states.
	// The pop is decoded combinationally in RD_WAIT_DATA.
	typedef enum logic [1:0] {
		RD_WAIT_DATA = 2'd0,
		RD_LOAD      = 2'd1,
		RD_READY     = 2'd2
	} rd_state_e;

	// Host word, zero extended above the status bit.
	typedef struct packed {
		logic [RDATA_WIDTH-uart_line_pkg::DATA_BITS-2:0] reserved;
		logic                                             frame_err;
		logic [uart_line_pkg::DATA_BITS-1:0]              data;
	} rdata_t;

endpackage

/* rtl/baud_tick_gen.sv */
`timescale 1ns/100ps

module baud_tick_gen #(
	parameter int CLOCK_RATE = 50_000_000,
	parameter int BAUD_RATE  = 9600
) (
	input  logic i_reset,
	input  logic baud_rx_clock,
	output logic o_tick
);

	import uart_line_pkg::*;

	localparam int DIVIDE = CLOCK_RATE / (BAUD_RATE * OVERSAMPLE);
	localparam int CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
	localparam logic [CNT_W-1:0] LAST = CNT_W'(DIVIDE - 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			count  <= '0;
			o_tick <= 1'b0;
		end else begin
			o_tick <= (count == LAST);  // One cycle wide, once per wrap.
			if (count == LAST)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

endmodule

/* rtl/uart_rx_deserializer.sv */
`timescale 1ns/100ps

module uart_rx_deserializer (
	input  logic                     i_reset,
	input  logic                     baud_rx_clock,
	input  logic                     i_tick,
	input  logic                     i_rx_line,
	output logic                     o_push,
	output uart_line_pkg::rx_frame_t o_frame
);

	import uart_line_pkg::*;

	localparam int SAMPLE_W = $clog2(OVERSAMPLE);
	localparam int BIT_W = $clog2(DATA_BITS);
	localparam logic [SAMPLE_W-1:0] MID_BIT = SAMPLE_W'(OVERSAMPLE / 2 - 1);
	localparam logic [SAMPLE_W-1:0] FULL_BIT = SAMPLE_W'(OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_BITS - 1);

	logic                 rx_meta;
	logic                 rx_sync;
	rx_state_e            state;
	logic [SAMPLE_W-1:0]  sample_cnt;
	logic [BIT_W-1:0]     bit_cnt;
	logic [DATA_BITS-1:0] shift_reg;
	logic                 sample_data;
	logic                 sample_stop;

	// The line idles high, so the synchronizer comes out of reset at one.
	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx_line;
			rx_sync <= rx_meta;
		end
	end

	assign sample_data = i_tick && (state == RX_DATA_BITS) && (sample_cnt == FULL_BIT);
	assign sample_stop = i_tick && (state == RX_STOP_BIT) && (sample_cnt == FULL_BIT);

	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			state      <= RX_IDLE;
			sample_cnt <= '0;
			bit_cnt    <= '0;
			o_push     <= 1'b0;
		end else begin
			o_push <= sample_stop;
			if (i_tick) begin
				case (state)
					RX_IDLE: begin
						sample_cnt <= '0;
						bit_cnt    <= '0;
						if (!rx_sync)
							state <= RX_START_BIT;
					end
					RX_START_BIT: begin
						if (sample_cnt == MID_BIT) begin
							// A high line at mid start bit was only a glitch.
							state      <= rx_sync ? RX_IDLE : RX_DATA_BITS;
							sample_cnt <= '0;
						end else begin
							sample_cnt <= sample_cnt + 1'b1;
						end
					end
					RX_DATA_BITS: begin
						sample_cnt <= sample_cnt + 1'b1;  // Wraps to zero after the sample.
						if (sample_cnt == FULL_BIT) begin
							if (bit_cnt == LAST_BIT)
								state <= RX_STOP_BIT;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
					end
					RX_STOP_BIT: begin
						sample_cnt <= sample_cnt + 1'b1;
						if (sample_cnt == FULL_BIT)
							state <= RX_IDLE;
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// Bits arrive LSB first, so each new bit enters at the top.
	always_ff @(posedge baud_rx_clock) begin
		if (sample_data)
			shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
		if (sample_stop) begin
			o_frame.data      <= shift_reg;
			o_frame.frame_err <= !rx_sync;
		end
	end

endmodule

/* rtl/rx_fifo.sv */
`timescale 1ns/100ps

module rx_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                     i_reset,
	input  logic                     baud_rx_clock,
	input  logic                     i_push,
	input  uart_line_pkg::rx_frame_t i_wdata,
	input  logic                     i_pop,
	output uart_line_pkg::rx_frame_t o_rdata,
	output logic                     o_empty,
	output logic                     o_overrun
);

	import uart_line_pkg::*;

	localparam int ADDR_W = $clog2(FIFO_DEPTH);

	rx_frame_t     mem [FIFO_DEPTH];
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;
	logic            full;
	logic            do_push;
	logic            do_pop;

	// The extra pointer bit tells a full buffer from an empty one.
	assign full    = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
			(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
	assign o_empty = (wr_ptr == rd_ptr);
	assign do_push = i_push && !full;
	assign do_pop  = i_pop && !o_empty;

	always_ff @(posedge baud_rx_clock) begin
		if (do_push)
			mem[wr_ptr[ADDR_W-1:0]] <= i_wdata;
		if (do_pop)
			o_rdata <= mem[rd_ptr[ADDR_W-1:0]];  // Head is presented the cycle after the pop.
	end

	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			o_overrun <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (i_push && full)
				o_overrun <= 1'b1;  // Dropped frame. Stays set until reset.
		end
	end

endmodule

/* rtl/uart_rx_read_port.sv */
`timescale 1ns/100ps

module uart_rx_read_port (
	input  logic                     i_reset,
	input  logic                     baud_rx_clock,
	input  logic                     i_request,
	input  logic                     i_empty,
	input  uart_line_pkg::rx_frame_t i_frame,
	output logic                     o_pop,
	output uart_host_pkg::rdata_t    o_rdata,
	output logic                     o_ready
);

	import uart_host_pkg::*;

	rd_state_e rd_state;

	// The pop goes out in the first cycle a request meets a stored frame.
	assign o_pop   = (rd_state == RD_WAIT_DATA) && i_request && !i_empty;
	assign o_ready = (rd_state == RD_READY) && i_request;

	always_ff @(posedge baud_rx_clock) begin
		if (i_reset) begin
			rd_state <= RD_WAIT_DATA;
			o_rdata  <= '0;
		end else if (!i_request) begin
			rd_state <= RD_WAIT_DATA;  // Each word needs its own request.
		end else begin
			case (rd_state)
				RD_WAIT_DATA: begin
					if (!i_empty)
						rd_state <= RD_LOAD;
				end
				RD_LOAD: begin
					// The FIFO output has settled by now.
					o_rdata <= rdata_t'{
						reserved:  '0,
						frame_err: i_frame.frame_err,
						data:      i_frame.data
					};
					rd_state <= RD_READY;
				end
				RD_READY: begin
					rd_state <= RD_READY;
				end
				default: rd_state <= RD_WAIT_DATA;
			endcase
		end
	end

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx #(
	parameter int CLOCK_RATE = 50_000_000,
	parameter int BAUD_RATE  = 9600,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                  i_reset,
	input  logic                  baud_rx_clock,
	input  logic                  i_rx_line,
	input  logic                  i_request,
	output uart_host_pkg::rdata_t o_rdata,
	output logic                  o_ready,
	output logic                  o_overrun
);

	import uart_line_pkg::*;

	logic      tick;
	logic      push;
	rx_frame_t rx_frame;
	logic      pop;
	logic      empty;
	rx_frame_t head_frame;

	baud_tick_gen #(
		.CLOCK_RATE(CLOCK_RATE),
		.BAUD_RATE (BAUD_RATE)
	) u_baud_tick_gen (
		.i_reset      (i_reset),
		.baud_rx_clock(baud_rx_clock),
		.o_tick       (tick)
	);

	uart_rx_deserializer u_deserializer (
		.i_reset      (i_reset),
		.baud_rx_clock(baud_rx_clock),
		.i_tick       (tick),
		.i_rx_line    (i_rx_line),
		.o_push       (push),
		.o_frame      (rx_frame)
	);

	rx_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_rx_fifo (
		.i_reset      (i_reset),
		.baud_rx_clock(baud_rx_clock),
		.i_push       (push),
		.i_wdata      (rx_frame),
		.i_pop        (pop),
		.o_rdata      (head_frame),
		.o_empty      (empty),
		.o_overrun    (o_overrun)
	);

	uart_rx_read_port u_read_port (
		.i_reset      (i_reset),
		.baud_rx_clock(baud_rx_clock),
		.i_request    (i_request),
		.i_empty      (empty),
		.i_frame      (head_frame),
		.o_pop        (pop),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready)
	);

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter real CLOCK_PERIOD = 40.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic baud_rx_clock,
	output logic o_reset
);

	initial begin
		baud_rx_clock = 1'b0;
		forever #(CLOCK_PERIOD / 2.0) baud_rx_clock = ~baud_rx_clock;
	end

	// Reset drops a little after a rising edge, like every other testbench input.
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge baud_rx_clock);
		#2;
		o_reset = 1'b0;
	end

endmodule

/* tests/uart_rx_tb.sv */
`timescale 1ns/100ps

module uart_rx_tb;

	import uart_host_pkg::*;

	localparam int  CLOCK_RATE   = 1_600_000;
	localparam int  BAUD_RATE    = 10_000;
	localparam int  FIFO_DEPTH   = 4;
	localparam int  BIT_CYCLES   = CLOCK_RATE / BAUD_RATE;  // 160 cycles per bit.
	localparam int  FRAME_CYCLES = 10 * BIT_CYCLES;
	localparam int  MAX_CYCLES   = 25 * FRAME_CYCLES;
	localparam int  READY_WAIT   = 2 * FRAME_CYCLES;
	localparam time DRIVE_DELAY  = 2;

	logic   baud_rx_clock;
	logic   i_reset;
	logic   i_rx_line;
	logic   i_request;
	rdata_t o_rdata;
	logic   o_ready;
	logic   o_overrun;
	int     mismatch_count;
	int     failure_count;
	int     cycle_count;
	int     seed;

	tb_clock_gen #(
		.CLOCK_PERIOD(40.0),
		.RESET_CYCLES(5)
	) u_clock_gen (
		.baud_rx_clock(baud_rx_clock),
		.o_reset      (i_reset)
	);

	uart_rx #(
		.CLOCK_RATE(CLOCK_RATE),
		.BAUD_RATE (BAUD_RATE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_dut (
		.i_reset      (i_reset),
		.baud_rx_clock(baud_rx_clock),
		.i_rx_line    (i_rx_line),
		.i_request    (i_request),
		.o_rdata      (o_rdata),
		.o_ready      (o_ready),
		.o_overrun    (o_overrun)
	);

	task automatic wait_drive_point();
		@(posedge baud_rx_clock);
		#DRIVE_DELAY;
	endtask

	task automatic wait_sample_point();
		@(negedge baud_rx_clock);  // Outputs are settled half a cycle after the edge.
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s is 0x%h, expected 0x%h", $time, name, actual,
					expected);
			mismatch_count++;
		end
	endtask

	function automatic rdata_t expected_word(input logic [7:0] data, input logic frame_err);
		rdata_t word;
		word = '0;
		word.data = data;
		word.frame_err = frame_err;
		return word;
	endfunction

	// Start bit, eight data bits LSB first, then the given stop bit, each a whole bit time.
	task automatic send_byte(input logic [7:0] value, input logic stop_bit);
		logic [9:0] frame_bits;
		int         i;
		frame_bits = {stop_bit, value, 1'b0};
		for (i = 0; i < 10; i++) begin
			wait_drive_point();
			i_rx_line = frame_bits[i];
			repeat (BIT_CYCLES - 1) @(posedge baud_rx_clock);
		end
		wait_drive_point();
		i_rx_line = 1'b1;
	endtask

	task automatic read_word(output rdata_t word, output logic got_word);
		int waited;
		word = '0;
		got_word = 1'b0;
		waited = 0;
		wait_drive_point();
		i_request = 1'b1;
		wait_sample_point();
		while (!o_ready && waited < READY_WAIT) begin
			wait_sample_point();
			waited++;
		end
		if (o_ready) begin
			word = o_rdata;
			got_word = 1'b1;
		end else begin
			$display("Failure at %0t: o_ready never rose after a read request", $time);
			failure_count++;
		end
		wait_drive_point();
		i_request = 1'b0;
		wait_sample_point();
		check_value("o_ready", o_ready, 1'b0);  // Ready follows the request down.
	endtask

	task automatic read_and_check(input logic [7:0] data, input logic frame_err);
		rdata_t word;
		logic   got_word;
		read_word(word, got_word);
		if (got_word)
			check_value("o_rdata", word, expected_word(data, frame_err));
	endtask

	task automatic expect_no_word(input int cycles);
		int waited;
		wait_drive_point();
		i_request = 1'b1;
		for (waited = 0; waited < cycles; waited++) begin
			wait_sample_point();
			if (o_ready) begin
				$display("Failure at %0t: o_ready rose although no word was expected", $time);
				failure_count++;
				break;
			end
		end
		wait_drive_point();
		i_request = 1'b0;
	endtask

	task automatic reset_defaults();
		wait_sample_point();
		check_value("o_ready", o_ready, 1'b0);
		check_value("o_overrun", o_overrun, 1'b0);
		check_value("o_rdata", o_rdata, 32'h0);
		expect_no_word(200);
	endtask

	task automatic single_byte_roundtrip();
		send_byte(8'hA5, 1'b1);
		read_and_check(8'hA5, 1'b0);
	endtask

	task automatic random_byte_stream();
		logic [7:0] value;
		int         n;
		for (n = 0; n < 8; n++) begin
			value = $random(seed);
			send_byte(value, 1'b1);
			read_and_check(value, 1'b0);
		end
	endtask

	task automatic framing_error_flag();
		send_byte(8'h3C, 1'b0);
		repeat (BIT_CYCLES) @(posedge baud_rx_clock);
		read_and_check(8'h3C, 1'b1);
	endtask

	task automatic start_glitch_rejection();
		wait_drive_point();
		i_rx_line = 1'b0;
		repeat (30) @(posedge baud_rx_clock);  // Three oversample ticks.
		#DRIVE_DELAY;
		i_rx_line = 1'b1;
		repeat (2 * BIT_CYCLES) @(posedge baud_rx_clock);
		expect_no_word(FRAME_CYCLES);  // A frame started by the pulse would be pushed by now.
		send_byte(8'h5A, 1'b1);
		read_and_check(8'h5A, 1'b0);
	endtask

	task automatic overrun_drop();
		logic [7:0] sent [5];
		int         n;
		sent = '{8'h11, 8'h82, 8'hC3, 8'h7E, 8'hF0};
		wait_sample_point();
		check_value("o_overrun", o_overrun, 1'b0);
		for (n = 0; n < 5; n++)
			send_byte(sent[n], 1'b1);
		wait_sample_point();
		check_value("o_overrun", o_overrun, 1'b1);
		for (n = 0; n < 4; n++)
			read_and_check(sent[n], 1'b0);
		expect_no_word(200);  // The fifth byte was dropped.
	endtask

	always @(posedge baud_rx_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		i_rx_line = 1'b1;  // Idle line.
		i_request = 1'b0;
		mismatch_count = 0;
		failure_count = 0;
		cycle_count = 0;
		seed = 32'h5fe2;
		wait (i_reset === 1'b0);
		reset_defaults();
		single_byte_roundtrip();
		random_byte_stream();
		framing_error_flag();
		start_glitch_rejection();
		overrun_drop();
		$display("Summary: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* uart_rx.f */
rtl/uart_line_pkg.sv
rtl/uart_host_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_rx_deserializer.sv
rtl/rx_fifo.sv
rtl/uart_rx_read_port.sv
rtl/uart_rx.sv
tests/tb_clock_gen.sv
tests/uart_rx_tb.sv
